// ==== vlog.f ====
iob_wb_pkg.sv
iob_iob2wishbone.sv
wb_decoder.sv
wb_sram.sv
wb_gpio_regs.sv
iob_wb_top.sv
tb_iob_wb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the IOb to Wishbone testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module tb_iob_wb_top \
  --Mdir obj_dir \
  -o tb_iob_wb_top

# the simulation result is taken from the log below
./obj_dir/tb_iob_wb_top | tee sim.log

if grep -q "Verification passed" sim.log; then
  echo "simulation result: PASS"
else
  echo "simulation result: FAIL"
  exit 1
fi

// ==== tb_iob_wb_top.sv ====
// ##################################################
// testbench for iob_wb_top: LFSR driven IOb traffic
// checked against a model of the SRAM and registers
// ##################################################
`default_nettype none

module tb_iob_wb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ADDR_W     = 20;
  localparam int SRAM_DEPTH = 256;
  localparam int READ_BYTES = 4;
  localparam int SRAM_AW    = $clog2(SRAM_DEPTH);
  localparam int CLK_PERIOD = 8;

  localparam int NUM_SRAM  = 300;
  localparam int NUM_REGS  = 60;
  localparam int NUM_UNMAP = 40;
  localparam int NUM_BURST = 64;
  // fill and final sweep touch every SRAM word once each
  localparam int NUM_SINGLE = 2 * SRAM_DEPTH + NUM_SRAM + NUM_REGS + NUM_UNMAP + 12;
  localparam int TIMEOUT_CYCLES = NUM_SINGLE * 6 + NUM_BURST * 2 + 200;

  logic              clk;
  logic              arst_n;
  logic              iob_valid;
  logic [ADDR_W-1:0] iob_addr;
  iob_wb_pkg::word_t iob_wdata;
  iob_wb_pkg::strb_t iob_wstrb;
  logic              iob_ready;
  logic              iob_rvalid;
  iob_wb_pkg::word_t iob_rdata;
  iob_wb_pkg::word_t gpio;

  // model state
  iob_wb_pkg::word_t sram_m [SRAM_DEPTH];
  iob_wb_pkg::word_t scratch_m;
  iob_wb_pkg::word_t gpio_m;
  logic [31:0]       lfsr_q;
  int                reads_issued;
  int                rvalid_seen;

  iob_wb_top #(
    .ADDR_W    (ADDR_W),
    .SRAM_DEPTH(SRAM_DEPTH),
    .READ_BYTES(READ_BYTES)
  ) dut_i (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .iob_valid_i (iob_valid),
    .iob_addr_i  (iob_addr),
    .iob_wdata_i (iob_wdata),
    .iob_wstrb_i (iob_wstrb),
    .iob_ready_o (iob_ready),
    .iob_rvalid_o(iob_rvalid),
    .iob_rdata_o (iob_rdata),
    .gpio_o      (gpio)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(negedge clk) begin
    if (iob_rvalid) begin
      rvalid_seen++;
    end
  end

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};  // one step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  function automatic iob_wb_pkg::strb_t write_strb();
    iob_wb_pkg::strb_t s;
    s = 4'(rand_bits(4));
    if (s == '0) begin
      s = 4'hF;  // zero strobe would turn it into a read
    end
    return s;
  endfunction

  function automatic logic [ADDR_W-1:0] sram_addr();
    return ADDR_W'(iob_wb_pkg::SRAM_BASE + (rand_bits(SRAM_AW) << 2));
  endfunction

  function automatic iob_wb_pkg::word_t merge_bytes(input iob_wb_pkg::word_t old_w,
                                                    input iob_wb_pkg::word_t new_w,
                                                    input iob_wb_pkg::strb_t strb);
    iob_wb_pkg::word_t m;
    m = old_w;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        m[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return m;
  endfunction

  function automatic iob_wb_pkg::word_t model_read(input logic [ADDR_W-1:0] addr);
    logic [31:0]       a;
    iob_wb_pkg::word_t r;
    a = 32'(addr);
    r = iob_wb_pkg::ERR_DATA;
    if ((a - iob_wb_pkg::SRAM_BASE) < 32'(SRAM_DEPTH * 4)) begin
      r = sram_m[a[SRAM_AW+1:2]];
    end else if ((a - iob_wb_pkg::REGS_BASE) < iob_wb_pkg::REGS_SPAN) begin
      case (a[3:2])
        2'd0:    r = iob_wb_pkg::ID_VALUE;
        2'd1:    r = scratch_m;
        2'd2:    r = gpio_m;
        default: r = ~scratch_m;
      endcase
    end
    return r;
  endfunction

  task automatic model_write(input logic [ADDR_W-1:0] addr, input iob_wb_pkg::word_t wdata,
                             input iob_wb_pkg::strb_t strb);
    logic [31:0] a;
    a = 32'(addr);
    if ((a - iob_wb_pkg::SRAM_BASE) < 32'(SRAM_DEPTH * 4)) begin
      sram_m[a[SRAM_AW+1:2]] = merge_bytes(sram_m[a[SRAM_AW+1:2]], wdata, strb);
    end else if ((a - iob_wb_pkg::REGS_BASE) < iob_wb_pkg::REGS_SPAN) begin
      if (a[3:2] == 2'd1) begin
        scratch_m = merge_bytes(scratch_m, wdata, strb);
      end else if (a[3:2] == 2'd2) begin
        gpio_m = merge_bytes(gpio_m, wdata, strb);
      end  // id and the mirror ignore writes
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input iob_wb_pkg::word_t exp,
                            input iob_wb_pkg::word_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
    end
  endtask

  // one request, then cycles 0 to 3 are checked mid cycle
  task automatic bus_access(input logic [ADDR_W-1:0] addr, input iob_wb_pkg::word_t wdata,
                            input iob_wb_pkg::strb_t strb, input string name);
    iob_wb_pkg::word_t exp;
    logic              is_read;
    is_read = (strb == '0);
    exp = model_read(addr);
    @(negedge clk);
    while (!iob_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    iob_valid <= 1'b1;
    iob_addr  <= addr;
    iob_wdata <= wdata;
    iob_wstrb <= strb;
    @(negedge clk);  // accept cycle
    check_bit({name, " ready c0"}, 1'b1, iob_ready);
    check_bit({name, " rvalid c0"}, 1'b0, iob_rvalid);
    @(posedge clk);
    iob_valid <= 1'b0;
    if (is_read) begin
      reads_issued++;
    end else begin
      model_write(addr, wdata, strb);
    end
    @(negedge clk);  // slave ack
    check_bit({name, " ready c1"}, 1'b0, iob_ready);
    check_bit({name, " rvalid c1"}, 1'b0, iob_rvalid);
    @(negedge clk);
    check_bit({name, " ready c2"}, 1'b1, iob_ready);
    check_bit({name, " rvalid c2"}, is_read, iob_rvalid);
    if (is_read) begin
      check_word({name, " rdata"}, exp, iob_rdata);
    end
    @(negedge clk);
    check_bit({name, " rvalid c3"}, 1'b0, iob_rvalid);
  endtask

  // valid held high, one request every second cycle
  task automatic burst_traffic(input int n);
    logic [ADDR_W-1:0] addr;
    iob_wb_pkg::word_t wdata;
    iob_wb_pkg::strb_t strb;
    iob_wb_pkg::word_t exp_prev;
    logic              pend_read;
    pend_read = 1'b0;
    exp_prev  = '0;
    @(negedge clk);
    while (!iob_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    for (int k = 0; k < n; k++) begin
      addr  = sram_addr();
      strb  = rand_bits(1) ? write_strb() : '0;
      wdata = rand_bits(32);
      iob_valid <= 1'b1;
      iob_addr  <= addr;
      iob_wdata <= wdata;
      iob_wstrb <= strb;
      @(negedge clk);  // cycle 0 here is cycle 2 of the one before
      check_bit("burst ready c0", 1'b1, iob_ready);
      check_bit("burst rvalid c2", pend_read, iob_rvalid);
      if (pend_read) begin
        check_word("burst rdata", exp_prev, iob_rdata);
      end
      pend_read = (strb == '0);
      if (pend_read) begin
        exp_prev = model_read(addr);
        reads_issued++;
      end else begin
        model_write(addr, wdata, strb);
      end
      @(negedge clk);
      check_bit("burst ready c1", 1'b0, iob_ready);
      check_bit("burst rvalid c1", 1'b0, iob_rvalid);
      @(posedge clk);
    end
    iob_valid <= 1'b0;
    @(negedge clk);
    check_bit("burst last rvalid", pend_read, iob_rvalid);
    if (pend_read) begin
      check_word("burst last rdata", exp_prev, iob_rdata);
    end
    @(negedge clk);
    check_bit("burst idle rvalid", 1'b0, iob_rvalid);
  endtask

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    fail_run("timeout: the DUT stopped answering IOb requests");
  end

  initial begin
    logic [ADDR_W-1:0] addr;
    iob_wb_pkg::word_t wdata;
    logic              op;
    clk          = 1'b0;
    arst_n       = 1'b0;
    iob_valid    = 1'b0;
    iob_addr     = '0;
    iob_wdata    = '0;
    iob_wstrb    = '0;
    lfsr_q       = 32'h843a_a649;
    scratch_m    = '0;
    gpio_m       = '0;
    reads_issued = 0;
    rvalid_seen  = 0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;

    @(negedge clk);
    check_bit("reset ready", 1'b1, iob_ready);
    check_bit("reset rvalid", 1'b0, iob_rvalid);
    check_word("reset gpio", '0, gpio);

    // fill pattern over the whole word index
    for (int i = 0; i < SRAM_DEPTH; i++) begin
      wdata = (32'(i) * 32'h0101_0101) ^ 32'h5A3C_C3A5;
      bus_access(ADDR_W'(i * 4), wdata, 4'hF, "sram fill");
    end

    for (int i = 0; i < NUM_SRAM; i++) begin
      addr  = sram_addr();
      op    = rand_bits(1) != 0;
      wdata = rand_bits(32);
      if (op) begin
        bus_access(addr, wdata, write_strb(), "sram write");
      end else begin
        bus_access(addr, '0, '0, "sram read");
      end
    end

    bus_access(ADDR_W'(iob_wb_pkg::REGS_BASE), '0, '0, "id read");
    for (int i = 0; i < NUM_REGS; i++) begin
      addr  = ADDR_W'(iob_wb_pkg::REGS_BASE + (rand_bits(2) << 2));
      op    = rand_bits(1) != 0;
      wdata = rand_bits(32);
      if (op) begin
        bus_access(addr, wdata, write_strb(), "regs write");
      end else begin
        bus_access(addr, '0, '0, "regs read");
      end
      check_word("gpio out", gpio_m, gpio);
    end

    // the gap above the SRAM and the word past the registers
    bus_access(ADDR_W'(SRAM_DEPTH * 4), 32'h1234_5678, 4'hF, "gap write");
    bus_access(ADDR_W'(SRAM_DEPTH * 4), '0, '0, "gap read");
    bus_access(ADDR_W'(iob_wb_pkg::REGS_BASE + iob_wb_pkg::REGS_SPAN), '0, '0, "regs end read");
    for (int i = 0; i < NUM_UNMAP; i++) begin
      addr  = ADDR_W'(32'h0008_0000 | (rand_bits(17) << 2));
      op    = rand_bits(1) != 0;
      wdata = rand_bits(32);
      if (op) begin
        bus_access(addr, wdata, write_strb(), "unmapped write");
      end else begin
        bus_access(addr, '0, '0, "unmapped read");
      end
    end

    burst_traffic(NUM_BURST);

    // read back everything that an unmapped write could have hit
    for (int i = 0; i < SRAM_DEPTH; i++) begin
      bus_access(ADDR_W'(i * 4), '0, '0, "sram sweep");
    end
    for (int i = 0; i < 4; i++) begin
      bus_access(ADDR_W'(iob_wb_pkg::REGS_BASE + 32'(i * 4)), '0, '0, "regs sweep");
    end
    check_word("final gpio", gpio_m, gpio);

    if (rvalid_seen != reads_issued) begin
      fail_run($sformatf("saw %0d rvalid pulses for %0d reads", rvalid_seen, reads_issued));
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== iob_wb_top.sv ====
// ##################################################
// subsystem top: IOb bridge, Wishbone decoder, SRAM
// and register bank slaves
// ##################################################
`default_nettype none

module iob_wb_top #(
  parameter int ADDR_W     = 20,
  parameter int SRAM_DEPTH = 256,
  parameter int READ_BYTES = 4
) (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  wire                     iob_valid_i,
  input  wire  [ADDR_W-1:0]       iob_addr_i,
  input  wire  iob_wb_pkg::word_t iob_wdata_i,
  input  wire  iob_wb_pkg::strb_t iob_wstrb_i,
  output logic                    iob_ready_o,
  output logic                    iob_rvalid_o,
  output iob_wb_pkg::word_t       iob_rdata_o,
  output iob_wb_pkg::word_t       gpio_o
);

  localparam int SRAM_AW = $clog2(SRAM_DEPTH);

  logic [ADDR_W-1:0] wb_addr;
  iob_wb_pkg::word_t wb_data_w;
  iob_wb_pkg::word_t wb_data_r;
  iob_wb_pkg::strb_t wb_sel;
  logic              wb_we;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_ack;

  logic              sram_stb;
  logic              sram_ack;
  iob_wb_pkg::word_t sram_data;
  logic              regs_stb;
  logic              regs_ack;
  iob_wb_pkg::word_t regs_data;

  iob_iob2wishbone #(
    .ADDR_W    (ADDR_W),
    .READ_BYTES(READ_BYTES)
  ) bridge_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .iob_valid_i (iob_valid_i),
    .iob_addr_i  (iob_addr_i),
    .iob_wdata_i (iob_wdata_i),
    .iob_wstrb_i (iob_wstrb_i),
    .iob_ready_o (iob_ready_o),
    .iob_rvalid_o(iob_rvalid_o),
    .iob_rdata_o (iob_rdata_o),
    .wb_addr_o   (wb_addr),
    .wb_data_o   (wb_data_w),
    .wb_select_o (wb_sel),
    .wb_we_o     (wb_we),
    .wb_cyc_o    (wb_cyc),
    .wb_stb_o    (wb_stb),
    .wb_ack_i    (wb_ack),
    .wb_data_i   (wb_data_r)
  );

  wb_decoder #(
    .ADDR_W    (ADDR_W),
    .SRAM_DEPTH(SRAM_DEPTH)
  ) decoder_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .wb_addr_i  (wb_addr),
    .wb_cyc_i   (wb_cyc),
    .wb_stb_i   (wb_stb),
    .sram_stb_o (sram_stb),
    .regs_stb_o (regs_stb),
    .sram_ack_i (sram_ack),
    .sram_data_i(sram_data),
    .regs_ack_i (regs_ack),
    .regs_data_i(regs_data),
    .wb_ack_o   (wb_ack),
    .wb_data_o  (wb_data_r)
  );

  wb_sram #(
    .SRAM_DEPTH(SRAM_DEPTH)
  ) sram_i (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .stb_i   (sram_stb),
    .we_i    (wb_we),
    .addr_i  (wb_addr[SRAM_AW+1:2]),  // byte address to word index
    .sel_i   (wb_sel),
    .data_i  (wb_data_w),
    .ack_o   (sram_ack),
    .data_o  (sram_data)
  );

  wb_gpio_regs regs_i (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .stb_i   (regs_stb),
    .we_i    (wb_we),
    .addr_i  (wb_addr[3:2]),
    .sel_i   (wb_sel),
    .data_i  (wb_data_w),
    .ack_o   (regs_ack),
    .data_o  (regs_data),
    .gpio_o  (gpio_o)
  );

endmodule

`default_nettype wire

// ==== wb_gpio_regs.sv ====
// ##################################################
// Wishbone register bank: id, scratch and gpio output
// word, byte strobed writes, ack one cycle after stb
// ##################################################
`default_nettype none

module wb_gpio_regs (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  wire                     stb_i,
  input  wire                     we_i,
  input  wire  [1:0]              addr_i,  // word offset
  input  wire  iob_wb_pkg::strb_t sel_i,
  input  wire  iob_wb_pkg::word_t data_i,
  output logic                    ack_o,
  output iob_wb_pkg::word_t       data_o,
  output iob_wb_pkg::word_t       gpio_o
);

  localparam int LANES = $bits(iob_wb_pkg::strb_t);

  iob_wb_pkg::word_t scratch_q;
  iob_wb_pkg::word_t gpio_q;
  iob_wb_pkg::word_t rd_word;
  iob_wb_pkg::word_t rdata_q;
  logic              ack_q;
  logic              start;
  logic              wr_scratch;
  logic              wr_gpio;

  assign start      = stb_i & ~ack_q;
  assign wr_scratch = start & we_i & (addr_i == iob_wb_pkg::REG_SCRATCH);
  assign wr_gpio    = start & we_i & (addr_i == iob_wb_pkg::REG_GPIO);

  assign ack_o  = ack_q;
  assign data_o = rdata_q;
  assign gpio_o = gpio_q;

  always_comb begin
    case (addr_i)
      iob_wb_pkg::REG_ID:      rd_word = iob_wb_pkg::ID_VALUE;
      iob_wb_pkg::REG_SCRATCH: rd_word = scratch_q;
      iob_wb_pkg::REG_GPIO:    rd_word = gpio_q;
      default:                 rd_word = ~scratch_q;  // read only mirror
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q     <= 1'b0;
      scratch_q <= '0;
      gpio_q    <= '0;
    end else begin
      ack_q <= start;
      for (int i = 0; i < LANES; i++) begin
        if (wr_scratch && sel_i[i]) begin
          scratch_q[8*i +: 8] <= data_i[8*i +: 8];
        end
        if (wr_gpio && sel_i[i]) begin
          gpio_q[8*i +: 8] <= data_i[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start && !we_i) begin
      rdata_q <= rd_word;
    end
  end

endmodule

`default_nettype wire

// ==== wb_sram.sv ====
// ##################################################
// Wishbone SRAM slave, byte select writes, registered
// read word, ack one cycle after the strobe
// ##################################################
`default_nettype none

module wb_sram #(
  parameter int SRAM_DEPTH = 256
) (
  input  wire                            clk_i,
  input  wire                            arst_n_i,
  input  wire                            stb_i,
  input  wire                            we_i,
  input  wire  [$clog2(SRAM_DEPTH)-1:0]  addr_i,  // word index
  input  wire  iob_wb_pkg::strb_t        sel_i,
  input  wire  iob_wb_pkg::word_t        data_i,
  output logic                           ack_o,
  output iob_wb_pkg::word_t              data_o
);

  localparam int LANES = $bits(iob_wb_pkg::strb_t);

  iob_wb_pkg::word_t mem [SRAM_DEPTH];
  iob_wb_pkg::word_t rdata_q;
  logic              ack_q;
  logic              start;

  assign start  = stb_i & ~ack_q;  // first strobe cycle without ack
  assign ack_o  = ack_q;
  assign data_o = rdata_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= start;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      if (we_i) begin
        for (int i = 0; i < LANES; i++) begin
          if (sel_i[i]) begin
            mem[addr_i][8*i +: 8] <= data_i[8*i +: 8];
          end
        end
      end else begin
        rdata_q <= mem[addr_i];  // valid alongside ack
      end
    end
  end

  // the bridge turns a zero strobe into a read
  write_has_lanes : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (stb_i && we_i) |-> (sel_i != '0)
  ) else $error("sram write with empty select");

endmodule

`default_nettype wire

// ==== wb_decoder.sv ====
// ##################################################
// Wishbone address decoder for the SRAM and register
// slaves, acks unmapped addresses with an error word
// ##################################################
`default_nettype none

module wb_decoder #(
  parameter int ADDR_W     = 20,
  parameter int SRAM_DEPTH = 256
) (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  wire  [ADDR_W-1:0]       wb_addr_i,
  input  wire                     wb_cyc_i,
  input  wire                     wb_stb_i,

  output logic                    sram_stb_o,
  output logic                    regs_stb_o,
  input  wire                     sram_ack_i,
  input  wire  iob_wb_pkg::word_t sram_data_i,
  input  wire                     regs_ack_i,
  input  wire  iob_wb_pkg::word_t regs_data_i,

  output logic                    wb_ack_o,
  output iob_wb_pkg::word_t       wb_data_o
);

  localparam iob_wb_pkg::word_t SRAM_SPAN = 32'(SRAM_DEPTH * 4);  // bytes

  iob_wb_pkg::word_t     addr_ext;
  iob_wb_pkg::wb_slave_e slave;
  logic                  req;
  logic                  err_ack_q;

  assign addr_ext = 32'(wb_addr_i);
  assign req      = wb_cyc_i & wb_stb_i;

  // an address below a base wraps to a large unsigned offset
  always_comb begin
    if ((addr_ext - iob_wb_pkg::SRAM_BASE) < SRAM_SPAN) begin
      slave = iob_wb_pkg::SLV_SRAM;
    end else if ((addr_ext - iob_wb_pkg::REGS_BASE) < iob_wb_pkg::REGS_SPAN) begin
      slave = iob_wb_pkg::SLV_REGS;
    end else begin
      slave = iob_wb_pkg::SLV_NONE;
    end
  end

  assign sram_stb_o = req & (slave == iob_wb_pkg::SLV_SRAM);
  assign regs_stb_o = req & (slave == iob_wb_pkg::SLV_REGS);

  // own single cycle ack for unmapped addresses
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_ack_q <= 1'b0;
    end else begin
      err_ack_q <= req & (slave == iob_wb_pkg::SLV_NONE) & ~err_ack_q;
    end
  end

  always_comb begin
    case (slave)
      iob_wb_pkg::SLV_SRAM: begin
        wb_ack_o  = sram_ack_i;
        wb_data_o = sram_data_i;
      end
      iob_wb_pkg::SLV_REGS: begin
        wb_ack_o  = regs_ack_i;
        wb_data_o = regs_data_i;
      end
      default: begin
        wb_ack_o  = err_ack_q;
        wb_data_o = iob_wb_pkg::ERR_DATA;
      end
    endcase
  end

  // at most one responder acks in any cycle
  one_slave_acks : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({sram_ack_i, regs_ack_i, err_ack_q})
  ) else $error("more than one slave ack");

endmodule

`default_nettype wire

// ==== iob_iob2wishbone.sv ====
// ##################################################
// IOb native bus to Wishbone classic bridge, one
// Wishbone cycle per accepted IOb request
// ##################################################
`default_nettype none

module iob_iob2wishbone #(
  parameter int ADDR_W     = 20,
  parameter int READ_BYTES = 4
) (
  input  wire                     clk_i,
  input  wire                     arst_n_i,

  // IOb side
  input  wire                     iob_valid_i,
  input  wire  [ADDR_W-1:0]       iob_addr_i,
  input  wire  iob_wb_pkg::word_t iob_wdata_i,
  input  wire  iob_wb_pkg::strb_t iob_wstrb_i,
  output logic                    iob_ready_o,
  output logic                    iob_rvalid_o,
  output iob_wb_pkg::word_t       iob_rdata_o,

  // Wishbone side
  output logic [ADDR_W-1:0]       wb_addr_o,
  output iob_wb_pkg::word_t       wb_data_o,
  output iob_wb_pkg::strb_t       wb_select_o,
  output logic                    wb_we_o,
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  input  wire                     wb_ack_i,
  input  wire  iob_wb_pkg::word_t wb_data_i
);

  localparam logic [7:0] RB_MASK = 8'((1 << READ_BYTES) - 1);

  logic              accept;
  logic              we_live;
  logic [7:0]        rd_sel;
  iob_wb_pkg::strb_t sel_live;

  // held copies of the request
  logic              valid_q;
  logic [ADDR_W-1:0] addr_q;
  iob_wb_pkg::word_t wdata_q;
  iob_wb_pkg::strb_t sel_q;
  logic              we_q;

  // registered response
  logic              ack_q;
  iob_wb_pkg::word_t rdata_q;

  assign accept   = iob_valid_i & iob_ready_o;
  assign we_live  = |iob_wstrb_i;  // zero strobe means read
  assign rd_sel   = RB_MASK << iob_addr_i[1:0];
  assign sel_live = we_live ? iob_wstrb_i : rd_sel[3:0];

  // live request in the accept cycle, held copy until ack
  assign wb_addr_o   = accept ? iob_addr_i : addr_q;
  assign wb_data_o   = accept ? iob_wdata_i : wdata_q;
  assign wb_select_o = accept ? sel_live : sel_q;
  assign wb_we_o     = accept ? we_live : we_q;
  assign wb_cyc_o    = accept | valid_q;
  assign wb_stb_o    = wb_cyc_o;

  assign iob_ready_o  = ~valid_q;
  assign iob_rvalid_o = ack_q & ~we_q;  // reads only
  assign iob_rdata_o  = rdata_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      if (accept) begin
        valid_q <= 1'b1;
      end else if (wb_ack_i) begin
        valid_q <= 1'b0;
      end
      ack_q <= wb_ack_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= iob_addr_i;
      wdata_q <= iob_wdata_i;
      sel_q   <= sel_live;
      we_q    <= we_live;
    end
    if (wb_ack_i) begin
      rdata_q <= wb_data_i;  // shown with rvalid one cycle later
    end
  end

  // slaves only answer an open cycle
  ack_inside_cycle : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    wb_ack_i |-> wb_cyc_o
  ) else $error("wishbone ack without cyc");

endmodule

`default_nettype wire

// ==== iob_wb_pkg.sv ====
// ##################################################
// word types, memory map and constants shared by the
// IOb to Wishbone subsystem, used as iob_wb_pkg::name
// ##################################################
`default_nettype none

package iob_wb_pkg;

  typedef logic [31:0] word_t;  // one bus word
  typedef logic [3:0]  strb_t;  // one bit per byte lane

  // target picked by the address decoder
  typedef enum logic [1:0] {
    SLV_SRAM = 2'd0,
    SLV_REGS = 2'd1,
    SLV_NONE = 2'd2
  } wb_slave_e;

  // memory map in byte addresses
  localparam word_t SRAM_BASE = 32'h0000_0000;
  localparam word_t REGS_BASE = 32'h0001_0000;
  localparam word_t REGS_SPAN = 32'd16;  // four words

  localparam word_t ID_VALUE = 32'h10B0_0B01;  // read only id word
  localparam word_t ERR_DATA = 32'hDEAD_BEEF;  // returned for unmapped reads

  // word offsets in the register window
  localparam logic [1:0] REG_ID      = 2'd0;
  localparam logic [1:0] REG_SCRATCH = 2'd1;
  localparam logic [1:0] REG_GPIO    = 2'd2;
  // offset 3 reads back the inverse of scratch

endpackage

`default_nettype wire
